// File: rf_pkg.sv
/*
 * Shared sizes, address split and word types of the banked register file.
 * Compile this package before any module of the design.
 */
package rf_pkg;

    // ################################################
    // Sizes
    // ################################################

    // Register word width
    localparam int unsigned DATA_W        = 32;
    // Word-interleaved banks
    localparam int unsigned NUM_BANKS     = 4;
    // Registers in each bank
    localparam int unsigned REGS_PER_BANK = 16;

    // ################################################
    // Address split
    // ################################################

    // Low bits of the word address pick the bank
    localparam int unsigned BANK_SEL_W = $clog2(NUM_BANKS);
    // Upper bits pick the register inside the bank
    localparam int unsigned REG_ADDR_W = $clog2(REGS_PER_BANK);
    // Full Wishbone word address
    localparam int unsigned WB_ADR_W   = BANK_SEL_W + REG_ADDR_W;

    // ################################################
    // Types
    // ################################################

    // One register word
    typedef logic [DATA_W-1:0]     data_t;

    // Register index within a bank
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Bank index, also carried as the read tag
    typedef logic [BANK_SEL_W-1:0] bank_sel_t;

    // Wishbone word address, {register index, bank index}
    typedef logic [WB_ADR_W-1:0]   wb_adr_t;

endpackage : rf_pkg

// File: register_file_bank.sv
/*
 * Single-port register bank with write priority and one-cycle read latency.
 * The read tag is delayed alongside the data so responses can be steered back.
 */
module register_file_bank (
    // Clock and reset
    input  logic               clk_i,
    input  logic               arst_n_i,

    // Write port
    input  logic               write_valid_i,
    input  rf_pkg::reg_addr_t  write_addr_i,
    input  rf_pkg::data_t      write_data_i,
    output logic               write_ready_o,

    // Read port
    input  logic               read_valid_i,
    input  rf_pkg::reg_addr_t  read_addr_i,
    input  rf_pkg::bank_sel_t  read_tag_i,
    output logic               read_ready_o,

    // Read response, one cycle after acceptance
    output logic               read_valid_o,
    output rf_pkg::bank_sel_t  read_tag_o,
    output rf_pkg::data_t      read_data_o
);
    import rf_pkg::*;

    // ################################################
    // Signals
    // ################################################

    // Storage array, contents unknown until cleared
    data_t mem_q [REGS_PER_BANK];

    // Accepted operations this cycle
    logic  write_fire;
    logic  read_fire;

    // ################################################
    // Port arbitration
    // ################################################

    // Write always wins the single port
    assign write_fire = write_valid_i;

    // Read only goes when no write is pending
    assign read_fire  = read_valid_i && !write_valid_i;

    // Each side stalls while the other owns the port
    assign read_ready_o  = !write_valid_i;
    assign write_ready_o = !(read_valid_i && !write_valid_i);

    // ################################################
    // Memory
    // ################################################

    // Write into the array
    always_ff @(posedge clk_i) begin
        if (write_fire) begin
            mem_q[write_addr_i] <= write_data_i;
        end
    end

    // Read word registered, mirrors a synchronous SRAM
    always_ff @(posedge clk_i) begin
        if (read_fire) begin
            read_data_o <= mem_q[read_addr_i];
        end
    end

    // ################################################
    // Response control
    // ################################################

    // Valid and tag follow the accepted read by one cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            read_valid_o <= 1'b0;
            read_tag_o   <= '0;
        end else begin
            read_valid_o <= read_fire;
            // Tag only updates on a real read
            if (read_fire) begin
                read_tag_o <= read_tag_i;
            end
        end
    end

    // ################################################
    // Assertions
    // ################################################

    // A response needs a read accepted the cycle before
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        read_valid_o |-> $past(read_valid_i && read_ready_o))
        else $error("Read response without an accepted read");

endmodule : register_file_bank

// File: rf_clear_counter.sv
/*
 * Sweeps every register index once after reset so the banks can be zeroed.
 * Flags done when the sweep is over and holds it until the next reset.
 */
module rf_clear_counter (
    // Clock and reset
    input  logic              clk_i,
    input  logic              arst_n_i,

    // Clear sweep towards the front end
    output logic              clear_valid_o,
    output rf_pkg::reg_addr_t clear_addr_o,
    output logic              clear_done_o
);
    import rf_pkg::*;

    // One spare bit so an overrun would be visible
    logic [REG_ADDR_W:0] cnt_q;

    // Sticky completion flag
    logic                done_q;

    // ################################################
    // Counter
    // ################################################

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else if (!done_q) begin
            // Last index reached, wrap and finish
            if (cnt_q == REGS_PER_BANK - 1) begin
                cnt_q  <= '0;
                done_q <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Sweep runs until done
    assign clear_valid_o = !done_q;
    assign clear_addr_o  = cnt_q[REG_ADDR_W-1:0];
    assign clear_done_o  = done_q;

    // ################################################
    // Assertions
    // ################################################

    // Index never runs past the last register
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cnt_q < REGS_PER_BANK)
        else $error("Clear index out of range");

endmodule : rf_clear_counter

// File: rf_wb_fsm.sv
/*
 * Wishbone classic slave front end for the banked register file.
 * Broadcasts the zero clear, issues bank writes and tagged reads, returns data.
 */
module rf_wb_fsm (
    // Clock and reset
    input  logic              clk_i,
    input  logic              arst_n_i,

    // Wishbone classic slave
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  rf_pkg::wb_adr_t   wb_adr_i,
    input  rf_pkg::data_t     wb_dat_i,
    output rf_pkg::data_t     wb_dat_o,
    output logic              wb_ack_o,

    // Clear sweep
    input  logic              clear_valid_i,
    input  rf_pkg::reg_addr_t clear_addr_i,
    input  logic              clear_done_i,

    // Bank requests
    output logic              bank_write_valid_o [rf_pkg::NUM_BANKS],
    output logic              bank_read_valid_o  [rf_pkg::NUM_BANKS],
    output rf_pkg::reg_addr_t bank_addr_o,
    output rf_pkg::data_t     bank_write_data_o,
    output rf_pkg::bank_sel_t bank_read_tag_o,

    // Bank responses
    input  logic              bank_read_ready_i  [rf_pkg::NUM_BANKS],
    input  logic              bank_read_valid_i  [rf_pkg::NUM_BANKS],
    input  rf_pkg::bank_sel_t bank_read_tag_i    [rf_pkg::NUM_BANKS],
    input  rf_pkg::data_t     bank_read_data_i   [rf_pkg::NUM_BANKS]
);
    import rf_pkg::*;

    typedef enum logic [1:0] {
        CLEAR,
        IDLE,
        READ_WAIT,
        ACK
    } state_e;

    state_e state_q, state_d;

    // Address split
    bank_sel_t            req_bank;
    reg_addr_t            req_reg;
    logic                 req;

    // Response steering
    logic [NUM_BANKS-1:0] rsp_valid;
    bank_sel_t            rsp_tag;

    // Latched read word, payload only
    data_t                rdata_q;

    // Bank in low bits, register above
    assign req_bank = wb_adr_i[BANK_SEL_W-1:0];
    assign req_reg  = wb_adr_i[WB_ADR_W-1:BANK_SEL_W];
    assign req      = wb_cyc_i && wb_stb_i;

    // ################################################
    // Bank request drive
    // ################################################

    // Sweep index during clear, else the Wishbone register
    assign bank_addr_o       = (state_q == CLEAR) ? clear_addr_i : req_reg;
    assign bank_write_data_o = (state_q == CLEAR) ? '0 : wb_dat_i;
    // Bank index doubles as the tag
    assign bank_read_tag_o   = req_bank;

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_write_valid_o[b] = 1'b0;
            bank_read_valid_o[b]  = 1'b0;
            if (state_q == CLEAR) begin
                // Zero broadcast to every bank
                bank_write_valid_o[b] = clear_valid_i;
            end else if (state_q == IDLE && req && req_bank == bank_sel_t'(b)) begin
                bank_write_valid_o[b] = wb_we_i;
                bank_read_valid_o[b]  = !wb_we_i;
            end
        end
    end

    // ################################################
    // Response steering
    // ################################################

    // Pick up the tag of whichever bank answered
    always_comb begin
        rsp_tag = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            rsp_valid[b] = bank_read_valid_i[b];
            if (bank_read_valid_i[b]) begin
                rsp_tag = bank_read_tag_i[b];
            end
        end
    end

    // Returned tag selects the data source
    always_ff @(posedge clk_i) begin
        if (state_q == READ_WAIT && |rsp_valid) begin
            rdata_q <= bank_read_data_i[rsp_tag];
        end
    end

    assign wb_dat_o = rdata_q;
    assign wb_ack_o = (state_q == ACK);

    // ################################################
    // State machine
    // ################################################

    always_comb begin
        state_d = state_q;
        case (state_q)
            CLEAR: begin
                // Hold off Wishbone until sweep finishes
                if (clear_done_i) begin
                    state_d = IDLE;
                end
            end
            IDLE: begin
                if (req && wb_we_i) begin
                    state_d = ACK;
                end else if (req && bank_read_ready_i[req_bank]) begin
                    // Read stays pending while the bank is busy
                    state_d = READ_WAIT;
                end
            end
            READ_WAIT: begin
                if (|rsp_valid) begin
                    state_d = ACK;
                end
            end
            ACK: begin
                state_d = IDLE;
            end
            default: begin
                state_d = CLEAR;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= CLEAR;
        end else begin
            state_q <= state_d;
        end
    end

    // ################################################
    // Assertions
    // ################################################

    // Master must hold the strobe until it sees ack
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i))
        else $error("Ack without an active Wishbone cycle");

    // Only one bank answers at a time
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(rsp_valid))
        else $error("More than one bank read response");

endmodule : rf_wb_fsm

// File: banked_register_file.sv
/*
 * Top level: four word-interleaved banks behind a Wishbone classic slave.
 * busy_o stays high while the banks are cleared after reset.
 */
module banked_register_file (
    // Clock and reset
    input  logic            clk_i,
    input  logic            arst_n_i,

    // Wishbone classic slave
    input  logic            wb_cyc_i,
    input  logic            wb_stb_i,
    input  logic            wb_we_i,
    input  rf_pkg::wb_adr_t wb_adr_i,
    input  rf_pkg::data_t   wb_dat_i,
    output rf_pkg::data_t   wb_dat_o,
    output logic            wb_ack_o,

    // Clear sweep in progress
    output logic            busy_o
);
    import rf_pkg::*;

    // Clear counter to front end
    logic      clear_valid;
    reg_addr_t clear_addr;
    logic      clear_done;

    // Front end to banks
    logic      bank_write_valid [NUM_BANKS];
    logic      bank_read_valid  [NUM_BANKS];
    reg_addr_t bank_addr;
    data_t     bank_write_data;
    bank_sel_t bank_read_tag;

    // Banks back to front end
    logic      bank_read_ready  [NUM_BANKS];
    logic      bank_rsp_valid   [NUM_BANKS];
    bank_sel_t bank_rsp_tag     [NUM_BANKS];
    data_t     bank_rsp_data    [NUM_BANKS];

    assign busy_o = !clear_done;

    // ################################################
    // Clear sweep
    // ################################################

    rf_clear_counter i_clear (
        .clk_i         ( clk_i       ),
        .arst_n_i      ( arst_n_i    ),
        .clear_valid_o ( clear_valid ),
        .clear_addr_o  ( clear_addr  ),
        .clear_done_o  ( clear_done  )
    );

    // ################################################
    // Wishbone front end
    // ################################################

    rf_wb_fsm i_fsm (
        .clk_i              ( clk_i            ),
        .arst_n_i           ( arst_n_i         ),
        .wb_cyc_i           ( wb_cyc_i         ),
        .wb_stb_i           ( wb_stb_i         ),
        .wb_we_i            ( wb_we_i          ),
        .wb_adr_i           ( wb_adr_i         ),
        .wb_dat_i           ( wb_dat_i         ),
        .wb_dat_o           ( wb_dat_o         ),
        .wb_ack_o           ( wb_ack_o         ),
        .clear_valid_i      ( clear_valid      ),
        .clear_addr_i       ( clear_addr       ),
        .clear_done_i       ( clear_done       ),
        .bank_write_valid_o ( bank_write_valid ),
        .bank_read_valid_o  ( bank_read_valid  ),
        .bank_addr_o        ( bank_addr        ),
        .bank_write_data_o  ( bank_write_data  ),
        .bank_read_tag_o    ( bank_read_tag    ),
        .bank_read_ready_i  ( bank_read_ready  ),
        .bank_read_valid_i  ( bank_rsp_valid   ),
        .bank_read_tag_i    ( bank_rsp_tag     ),
        .bank_read_data_i   ( bank_rsp_data    )
    );

    // ################################################
    // Banks
    // ################################################

    for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
        // Writes never collide with a read here, write ready left open
        register_file_bank i_bank (
            .clk_i         ( clk_i               ),
            .arst_n_i      ( arst_n_i            ),
            .write_valid_i ( bank_write_valid[b] ),
            .write_addr_i  ( bank_addr           ),
            .write_data_i  ( bank_write_data     ),
            .write_ready_o (                     ),
            .read_valid_i  ( bank_read_valid[b]  ),
            .read_addr_i   ( bank_addr           ),
            .read_tag_i    ( bank_read_tag       ),
            .read_ready_o  ( bank_read_ready[b]  ),
            .read_valid_o  ( bank_rsp_valid[b]   ),
            .read_tag_o    ( bank_rsp_tag[b]     ),
            .read_data_o   ( bank_rsp_data[b]    )
        );
    end

endmodule : banked_register_file

// File: tb_banked_register_file.sv
/*
 * Testbench for the banked register file. Replays rf_stim.txt as Wishbone
 * classic transfers and checks read data, ack latency and busy_o against a model.
 */
module tb_banked_register_file;
    import rf_pkg::*;

    // ################################################
    // DUT signals
    // ################################################

    logic    clk_i;
    logic    arst_n_i;
    logic    wb_cyc_i;
    logic    wb_stb_i;
    logic    wb_we_i;
    wb_adr_t wb_adr_i;
    data_t   wb_dat_i;
    data_t   wb_dat_o;
    logic    wb_ack_o;
    logic    busy_o;

    // Stimulus, one entry per transaction line
    byte     op_q    [$];
    wb_adr_t adr_q   [$];
    data_t   dat_q   [$];
    logic    stall_q [$];

    // Reference copy of every word, zero after the clear
    data_t   model_mem [NUM_BANKS*REGS_PER_BANK];

    // Idle gap source
    logic [7:0] lfsr_q = 8'd76;

    // Watchdog
    int cycle_cnt;
    int cycle_limit;

    banked_register_file i_dut (
        .clk_i    ( clk_i    ),
        .arst_n_i ( arst_n_i ),
        .wb_cyc_i ( wb_cyc_i ),
        .wb_stb_i ( wb_stb_i ),
        .wb_we_i  ( wb_we_i  ),
        .wb_adr_i ( wb_adr_i ),
        .wb_dat_i ( wb_dat_i ),
        .wb_dat_o ( wb_dat_o ),
        .wb_ack_o ( wb_ack_o ),
        .busy_o   ( busy_o   )
    );

    // Period 10
    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ################################################
    // Error handling and compare tasks
    // ################################################

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // ################################################
    // Random idle gaps
    // ################################################

    // Galois step, taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 8'hB8;
        end
        return s >> 1;
    endfunction

    // 0 to 3 cycles with stb low, one LFSR step per bit
    task automatic insert_gap();
        int gap;
        gap = 0;
        for (int k = 0; k < 2; k++) begin
            gap    = (gap << 1) | lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
        if (gap > 0) begin
            @(posedge clk_i);
            wb_cyc_i <= 1'b0;
            wb_stb_i <= 1'b0;
            wb_we_i  <= 1'b0;
            repeat (gap - 1) @(posedge clk_i);
        end
    endtask

    // ################################################
    // Stimulus file
    // ################################################

    task automatic load_stimulus();
        int          fd;
        int          rc;
        string       line;
        byte         op;
        int          adr;
        logic [31:0] dat;
        int          stall;
        fd = $fopen("rf_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file rf_stim.txt");
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                // Comment and blank lines carry no transaction
                if (rc > 0 && line.substr(0, 0) != "#") begin
                    rc = $sscanf(line, "%c %h %h %d", op, adr, dat, stall);
                    if (rc == 4) begin
                        op_q.push_back(op);
                        adr_q.push_back(wb_adr_t'(adr));
                        dat_q.push_back(dat);
                        stall_q.push_back(stall != 0);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ################################################
    // One Wishbone classic transfer
    // ################################################

    task automatic do_transfer(input logic we, input wb_adr_t adr, input data_t dat,
                               input logic stall);
        int lat;
        @(posedge clk_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= we ? dat : '0;
        // busy_o as the DUT sees it in the first request cycle
        @(negedge clk_i);
        check_busy(busy_o, stall, $sformatf("busy_o at start of transfer to %h", adr));
        lat = 0;
        // Rising edges from stb until ack
        while (wb_ack_o !== 1'b1) begin
            @(posedge clk_i);
            lat++;
            @(negedge clk_i);
        end
        if (stall) begin
            check_busy(busy_o, 1'b0, "busy_o when a stalled transfer is acked");
        end else begin
            // Write acks one cycle after stb, read two
            check_latency(lat, we ? 1 : 2,
                $sformatf("ack latency of %s to %h", we ? "write" : "read", adr));
        end
        if (we) begin
            model_mem[adr] = dat;
        end else begin
            check_data(wb_dat_o, model_mem[adr], $sformatf("read of %h vs model", adr));
            check_data(wb_dat_o, dat, $sformatf("read of %h vs stimulus", adr));
        end
        insert_gap();
    endtask

    // ################################################
    // Main sequence
    // ################################################

    initial begin : main
        int n_xfer;
        arst_n_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        for (int a = 0; a < NUM_BANKS*REGS_PER_BANK; a++) begin
            model_mem[a] = '0;
        end
        load_stimulus();
        // A readback line stands for one transfer per address
        n_xfer = 0;
        foreach (op_q[i]) begin
            n_xfer += (op_q[i] == "A") ? NUM_BANKS*REGS_PER_BANK : 1;
        end
        cycle_limit = 16 + REGS_PER_BANK + n_xfer * 8 + 100;
        // Reset held 16 cycles
        repeat (16) @(posedge clk_i);
        arst_n_i <= 1'b1;
        foreach (op_q[i]) begin
            if (op_q[i] == "A") begin
                for (int a = 0; a < NUM_BANKS*REGS_PER_BANK; a++) begin
                    do_transfer(1'b0, wb_adr_t'(a), model_mem[a], 1'b0);
                end
            end else begin
                do_transfer(op_q[i] == "W", adr_q[i], dat_q[i], stall_q[i]);
            end
        end
        @(posedge clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        repeat (2) @(posedge clk_i);
        $display("test passed");
        $finish;
    end

    // busy_o high for the 16 sweep cycles after release, low from then on
    initial begin : busy_monitor
        int idx;
        idx = 0;
        wait (arst_n_i === 1'b1);
        forever begin
            @(negedge clk_i);
            check_busy(busy_o, idx < REGS_PER_BANK, "busy_o around the clear sweep");
            idx++;
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        forever begin
            @(posedge clk_i);
            cycle_cnt++;
            if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
                $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
                abort_run();
            end
        end
    end

endmodule : tb_banked_register_file

// File: all.f
rf_pkg.sv
register_file_bank.sv
rf_clear_counter.sv
rf_wb_fsm.sv
banked_register_file.sv
tb_banked_register_file.sv

// File: Bender.yml
package:
  name: banked_register_file

sources:
  # Design, package first
  - files:
      - rf_pkg.sv
      - register_file_bank.sv
      - rf_clear_counter.sv
      - rf_wb_fsm.sv
      - banked_register_file.sv

  # Testbench, reads rf_stim.txt from the project root
  - target: test
    files:
      - tb_banked_register_file.sv

// File: rf_stim.txt
# Columns: op (W write, R read, A read back all 64 words), word address (hex),
# write data or expected read data (hex), expect-stall flag (1 = issued while busy)
W 2a c0ffee01 1
R 00 00000000 0
R 3f 00000000 0
R 15 00000000 0
R 2a c0ffee01 0
W 05 12345678 0
R 05 12345678 0
W 06 9abcdef0 0
R 06 9abcdef0 0
W 10 11110000 0
W 11 22221111 0
W 12 33332222 0
W 13 44443333 0
R 10 11110000 0
R 11 22221111 0
R 12 33332222 0
R 13 44443333 0
W 14 55554444 0
R 04 00000000 0
R 14 55554444 0
W 3c a5a5a5a5 0
W 3d 5a5a5a5a 0
W 3e ffffffff 0
W 3f 00000001 0
R 3c a5a5a5a5 0
R 3d 5a5a5a5a 0
R 3e ffffffff 0
R 3f 00000001 0
W 05 0badf00d 0
R 05 0badf00d 0
R 06 9abcdef0 0
W 00 deadbeef 0
W 01 cafebabe 0
R 00 deadbeef 0
R 01 cafebabe 0
R 20 00000000 0
A 00 00000000 0
R 2a c0ffee01 0
